// File: files.f
rtl/mips_mem_pkg.sv
rtl/mem_stage.sv
rtl/data_ram.sv
rtl/mem_wb_reg.sv
rtl/wb_stage.sv
rtl/mem_wb_top.sv
verif/tb_mem_wb_top.sv

// File: verif/tb_mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb_top;
    import mips_mem_pkg::*;

    localparam int N_FILL     = 64;
    localparam int N_DIRECTED = 15;
    localparam int N_RANDOM   = 300;
    localparam int N_ITEMS    = N_FILL + N_DIRECTED + N_RANDOM;
    localparam int TIMEOUT    = N_ITEMS * 4 + 200;

    // one expected register write
    typedef struct packed
    {
        logic               we;
        logic [RNBITS-1:0]  addr;
        logic [NBITS-1:0]   data;
    } exp_t;

    logic               clk = 1'b0;
    logic               rst;
    logic               ex_valid;
    ex_mem_t            ex;
    logic               ex_ready;
    logic               rf_we;
    logic [RNBITS-1:0]  rf_addr;
    logic [NBITS-1:0]   rf_data;

    integer             seed = 32'h0cc2_eabf;
    int                 errors = 0;
    int                 writes = 0;
    int                 items_sent = 0;
    int                 cycles = 0;
    logic [NBITS-1:0]   shadow [64];    // model of the 64 words under test
    exp_t               exp_q [$];
    string              name_q [$];

    mem_wb_top #(.NBITS(NBITS), .DEPTH_WORDS(256)) mem_wb_top_inst
    (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_ex_valid (ex_valid),
        .i_ex       (ex),
        .o_ex_ready (ex_ready),
        .o_rf_we    (rf_we),
        .o_rf_addr  (rf_addr),
        .o_rf_data  (rf_data)
    );

    always #10 clk = ~clk;

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] fill_word(input int a);
        return (32'h9e37_79b9 * (a + 1)) ^ (a << 20);
    endfunction

    // expected write of one item, applying stores to the shadow memory
    function automatic exp_t apply_ref(input ex_mem_t it);
        exp_t           r;
        logic [5:0]     w;
        logic [1:0]     off;
        logic [31:0]    lane;
        logic [31:0]    loaded;
        w   = it.alu[7:2];
        off = it.alu[1:0];
        if (it.mem_op == MEM_STORE)
        begin
            case (it.store_size)
                SIZE_BYTE: shadow[w][8*off +: 8]  = it.store_data[7:0];
                SIZE_HALF: shadow[w][8*off +: 16] = it.store_data[15:0];
                default:   shadow[w] = it.store_data;
            endcase
        end
        lane = shadow[w] >> (8 * off);
        case (it.wb.load_size)
            SIZE_BYTE: loaded = it.wb.zero_extend ? {24'h0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
            SIZE_HALF: loaded = it.wb.zero_extend ? {16'h0, lane[15:0]} :
                                                    {{16{lane[15]}}, lane[15:0]};
            default:   loaded = shadow[w];
        endcase
        case (it.wb.wb_src)
            WB_MEM:  r.data = loaded;
            WB_PC4:  r.data = it.pc4;
            default: r.data = it.alu;
        endcase
        r.we   = it.wb.reg_write && (it.rd != 0);
        r.addr = it.rd;
        return r;
    endfunction

    function automatic ex_mem_t make_item(input mem_op_e op, input mem_size_e size,
                                          input logic [31:0] alu, input logic [31:0] sd,
                                          input logic [4:0] rd, input wb_src_e src,
                                          input logic rw, input logic zx);
        ex_mem_t it;
        it.pc4            = $random(seed);
        it.alu            = alu;
        it.store_data     = sd;
        it.rd             = rd;
        it.mem_op         = op;
        it.store_size     = (op == MEM_STORE) ? size : SIZE_WORD;
        it.wb.wb_src      = src;
        it.wb.reg_write   = rw;
        it.wb.load_size   = (op == MEM_LOAD) ? size : SIZE_WORD;
        it.wb.zero_extend = zx;
        return it;
    endfunction

    function automatic ex_mem_t random_item();
        int             kind;
        int             sz;
        logic [31:0]    addr;
        logic [31:0]    value;
        logic [4:0]     rd;
        logic           rw;
        logic           zx;
        kind  = {$random(seed)} % 4;
        sz    = {$random(seed)} % 3;
        addr  = ({$random(seed)} % 64) * 4;
        value = $random(seed);
        rd    = $random(seed);
        rw    = ({$random(seed)} % 8) != 0;   // mostly writing
        zx    = $random(seed);
        if (sz == 0)
            addr = addr + {$random(seed)} % 4;
        else if (sz == 1)
            addr = addr + 2 * ({$random(seed)} % 2);
        case (kind)
            0:       return make_item(MEM_NONE, SIZE_WORD, value, 0, rd,
                                      zx ? WB_PC4 : WB_ALU, rw, 1'b0);
            1:       return make_item(MEM_STORE, mem_size_e'(sz), addr, value, rd,
                                      WB_ALU, 1'b0, 1'b0);
            default: return make_item(MEM_LOAD, mem_size_e'(sz), addr, 0, rd, WB_MEM, rw, zx);
        endcase
    endfunction

    // called 2 ns after an edge, returns 2 ns after the accepting edge
    task automatic send_item(input ex_mem_t it, input string name);
        exp_t r;
        ex_valid = 1'b1;
        ex       = it;
        while (ex_ready !== 1'b1)
        begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        r = apply_ref(it);
        if (r.we)
        begin
            exp_q.push_back(r);
            name_q.push_back(name);
        end
        items_sent++;
        #2;
        ex_valid = 1'b0;
        ex       = '0;
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    initial
    begin : stimulus
        int i;
        rst      = 1'b1;
        ex_valid = 1'b0;
        ex       = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        idle(1);
        check_equal("reset ready", 32'd1, {31'd0, ex_ready});
        check_equal("reset write enable", 32'd0, {31'd0, rf_we});

        for (i = 0; i < N_FILL; i++)
            send_item(make_item(MEM_STORE, SIZE_WORD, i * 4, fill_word(i), 5'd0, WB_ALU,
                                1'b0, 1'b0), "fill");

        send_item(make_item(MEM_NONE, SIZE_WORD, 32'hdead_beef, 0, 5'd3, WB_ALU, 1'b1, 1'b0),
                  "alu write");
        send_item(make_item(MEM_NONE, SIZE_WORD, 32'h1234_5678, 0, 5'd31, WB_PC4, 1'b1, 1'b0),
                  "link write");
        send_item(make_item(MEM_NONE, SIZE_WORD, 32'h0bad_0bad, 0, 5'd5, WB_ALU, 1'b0, 1'b0),
                  "no reg_write");
        send_item(make_item(MEM_NONE, SIZE_WORD, 32'h0bad_0bad, 0, 5'd0, WB_ALU, 1'b1, 1'b0),
                  "rd zero");
        send_item(make_item(MEM_STORE, SIZE_WORD, 32'h40, 32'h1122_3344, 5'd0, WB_ALU,
                            1'b0, 1'b0), "store word");
        send_item(make_item(MEM_STORE, SIZE_BYTE, 32'h41, 32'h0000_00f0, 5'd0, WB_ALU,
                            1'b0, 1'b0), "store byte");
        send_item(make_item(MEM_STORE, SIZE_HALF, 32'h42, 32'h0000_8001, 5'd0, WB_ALU,
                            1'b0, 1'b0), "store half");
        send_item(make_item(MEM_LOAD, SIZE_WORD, 32'h40, 0, 5'd7, WB_MEM, 1'b1, 1'b0),
                  "lane merge");
        send_item(make_item(MEM_LOAD, SIZE_BYTE, 32'h41, 0, 5'd8, WB_MEM, 1'b1, 1'b0),
                  "byte signed");
        send_item(make_item(MEM_LOAD, SIZE_BYTE, 32'h41, 0, 5'd9, WB_MEM, 1'b1, 1'b1),
                  "byte zero");
        send_item(make_item(MEM_LOAD, SIZE_HALF, 32'h42, 0, 5'd10, WB_MEM, 1'b1, 1'b0),
                  "half signed");
        send_item(make_item(MEM_LOAD, SIZE_HALF, 32'h42, 0, 5'd11, WB_MEM, 1'b1, 1'b1),
                  "half zero");
        send_item(make_item(MEM_LOAD, SIZE_BYTE, 32'h40, 0, 5'd12, WB_MEM, 1'b1, 1'b0),
                  "byte lane 0");
        send_item(make_item(MEM_STORE, SIZE_WORD, 32'h80, 32'hcafe_f00d, 5'd0, WB_ALU,
                            1'b0, 1'b0), "store readback");
        send_item(make_item(MEM_LOAD, SIZE_WORD, 32'h80, 0, 5'd13, WB_MEM, 1'b1, 1'b0),
                  "word readback");

        for (i = 0; i < N_RANDOM; i++)
        begin
            send_item(random_item(), "random");
            idle({$random(seed)} % 2);      // valid gap
        end

        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);          // catch any late extra write

        $display("errors %0d, writes checked %0d, items sent %0d, pending %0d",
                 errors, writes, items_sent, exp_q.size());
        if (errors == 0 && exp_q.size() == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk)
    begin : monitor
        exp_t   e;
        string  n;
        if (!rst)
        begin
            if (rf_we === 1'b1)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("register write to r%0d with %h while no write was expected",
                             rf_addr, rf_data);
                end
                else
                begin
                    e = exp_q.pop_front();
                    n = name_q.pop_front();
                    check_equal({n, " addr"}, {27'd0, e.addr}, {27'd0, rf_addr});
                    check_equal({n, " data"}, e.data, rf_data);
                    writes++;
                end
            end
            else if (rf_we !== 1'b0)
            begin
                errors++;
                $display("write enable is unknown at %0t", $time);
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout after %0d cycles with %0d writes still pending",
                     cycles, exp_q.size());
            $display("TESTS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rtl/mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top
#(
    parameter int NBITS       = mips_mem_pkg::NBITS,
    parameter int DEPTH_WORDS = 256
)
(
    input  wire                                 i_clk,
    input  wire                                 i_rst,
    input  wire                                 i_ex_valid,
    input  wire mips_mem_pkg::ex_mem_t          i_ex,
    output logic                                o_ex_ready,
    output logic                                o_rf_we,
    output logic [mips_mem_pkg::RNBITS-1:0]     o_rf_addr,
    output logic [NBITS-1:0]                    o_rf_data
);
    import mips_mem_pkg::*;

    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic               wb_ack;
    logic [NBITS-3:0]   wb_adr;
    logic [NBITS-1:0]   wb_dat_w;
    logic [NBITS-1:0]   wb_dat_r;
    logic [NBITS/8-1:0] wb_sel;
    logic               mem_valid;
    logic               wb_valid;
    mem_wb_t            mem_item;
    mem_wb_t            wb_item;

    mem_stage #(.NBITS(NBITS)) mem_stage_inst
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_ex_valid  (i_ex_valid),
        .i_ex        (i_ex),
        .o_ex_ready  (o_ex_ready),
        .o_wb_cyc    (wb_cyc),
        .o_wb_stb    (wb_stb),
        .o_wb_we     (wb_we),
        .o_wb_adr    (wb_adr),
        .o_wb_dat    (wb_dat_w),
        .o_wb_sel    (wb_sel),
        .i_wb_dat    (wb_dat_r),
        .i_wb_ack    (wb_ack),
        .o_mem_valid (mem_valid),
        .o_mem       (mem_item)
    );

    data_ram #(.NBITS(NBITS), .DEPTH_WORDS(DEPTH_WORDS)) data_ram_inst
    (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_cyc (wb_cyc),
        .i_stb (wb_stb),
        .i_we  (wb_we),
        .i_adr (wb_adr),
        .i_dat (wb_dat_w),
        .i_sel (wb_sel),
        .o_dat (wb_dat_r),
        .o_ack (wb_ack)
    );

    mem_wb_reg #(.NBITS(NBITS)) mem_wb_reg_inst
    (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (mem_valid),
        .i_item  (mem_item),
        .o_valid (wb_valid),
        .o_item  (wb_item)
    );

    wb_stage #(.NBITS(NBITS)) wb_stage_inst
    (
        .i_valid   (wb_valid),
        .i_item    (wb_item),
        .o_rf_we   (o_rf_we),
        .o_rf_addr (o_rf_addr),
        .o_rf_data (o_rf_data)
    );

endmodule

`default_nettype wire

// File: rtl/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage
#(
    parameter int NBITS = mips_mem_pkg::NBITS
)
(
    input  wire                                 i_valid,
    input  wire mips_mem_pkg::mem_wb_t          i_item,
    output logic                                o_rf_we,
    output logic [mips_mem_pkg::RNBITS-1:0]     o_rf_addr,
    output logic [NBITS-1:0]                    o_rf_data
);
    import mips_mem_pkg::*;

    logic [NBITS-1:0]   lane;
    logic [7:0]         byte_v;
    logic [15:0]        half_v;
    logic               sgn_b;
    logic               sgn_h;
    logic [NBITS-1:0]   load_val;

    // bring the addressed byte or half down to bit 0, little endian
    assign lane   = i_item.mem_data >> {i_item.alu[1:0], 3'b000};
    assign byte_v = lane[7:0];
    assign half_v = lane[15:0];

    assign sgn_b = byte_v[7] && !i_item.wb.zero_extend;
    assign sgn_h = half_v[15] && !i_item.wb.zero_extend;

    always_comb
    begin
        case (i_item.wb.load_size)
            SIZE_BYTE: load_val = {{(NBITS-8){sgn_b}}, byte_v};
            SIZE_HALF: load_val = {{(NBITS-16){sgn_h}}, half_v};
            default:   load_val = i_item.mem_data;
        endcase
    end

    always_comb
    begin
        case (i_item.wb.wb_src)
            WB_MEM:  o_rf_data = load_val;
            WB_PC4:  o_rf_data = i_item.pc4;    // link
            default: o_rf_data = i_item.alu;
        endcase
    end

    // r0 is hardwired, never written
    assign o_rf_we   = i_valid && i_item.wb.reg_write && (i_item.rd != '0);
    assign o_rf_addr = i_item.rd;

endmodule

`default_nettype wire

// File: rtl/mem_wb_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg
#(
    parameter int NBITS = mips_mem_pkg::NBITS
)
(
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire                         i_valid,
    input  wire mips_mem_pkg::mem_wb_t  i_item,
    output logic                        o_valid,
    output mips_mem_pkg::mem_wb_t       o_item
);
    import mips_mem_pkg::*;

    logic       valid_q;
    logic       reg_write_q;
    mem_wb_t    item_q;

    if (NBITS != $bits(item_q.alu))
    begin : g_width_check
        $error("mem_wb_reg: NBITS does not match the item width");
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            valid_q     <= 1'b0;
            reg_write_q <= 1'b0;
        end
        else
        begin
            valid_q     <= i_valid;
            reg_write_q <= i_item.wb.reg_write;
        end
    end

    always_ff @(posedge i_clk)
        item_q <= i_item;

    always_comb
    begin
        o_item              = item_q;
        o_item.wb.reg_write = reg_write_q;  // reset copy overrides the payload
    end

    assign o_valid = valid_q;

endmodule

`default_nettype wire

// File: rtl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
#(
    parameter int NBITS       = mips_mem_pkg::NBITS,
    parameter int DEPTH_WORDS = 256
)
(
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire                 i_cyc,
    input  wire                 i_stb,
    input  wire                 i_we,
    input  wire  [NBITS-3:0]    i_adr,      // word address
    input  wire  [NBITS-1:0]    i_dat,
    input  wire  [NBITS/8-1:0]  i_sel,
    output logic [NBITS-1:0]    o_dat,
    output logic                o_ack
);
    localparam int AW = $clog2(DEPTH_WORDS);

    logic [NBITS-1:0]   mem [DEPTH_WORDS];
    logic               access;
    logic [AW-1:0]      idx;

    // one ack per strobe, the master drops stb on the ack edge
    assign access = i_cyc && i_stb && !o_ack;
    assign idx    = i_adr[AW-1:0];

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            o_ack <= 1'b0;
        else
            o_ack <= access;
    end

    always_ff @(posedge i_clk)
    begin
        if (access)
        begin
            if (i_we)
            begin
                for (int b = 0; b < NBITS/8; b++)
                begin
                    if (i_sel[b])
                        mem[idx][8*b +: 8] <= i_dat[8*b +: 8];     // lane write
                end
            end
            o_dat <= mem[idx];      // old word on a write, nobody reads it
        end
    end

    // ack only answers a strobe from the previous cycle of an open cycle
    a_ack_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_ack |-> (i_cyc && $past(i_stb)));

endmodule

`default_nettype wire

// File: rtl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
#(
    parameter int NBITS = mips_mem_pkg::NBITS
)
(
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire                         i_ex_valid,
    input  wire mips_mem_pkg::ex_mem_t  i_ex,
    output logic                        o_ex_ready,
    output logic                        o_wb_cyc,
    output logic                        o_wb_stb,
    output logic                        o_wb_we,
    output logic [NBITS-3:0]            o_wb_adr,
    output logic [NBITS-1:0]            o_wb_dat,
    output logic [NBITS/8-1:0]          o_wb_sel,
    input  wire  [NBITS-1:0]            i_wb_dat,
    input  wire                         i_wb_ack,
    output logic                        o_mem_valid,
    output mips_mem_pkg::mem_wb_t       o_mem
);
    import mips_mem_pkg::*;

    typedef enum logic
    {
        IDLE = 1'b0,
        BUS  = 1'b1
    } state_e;

    state_e     state;
    logic       ready_q;
    logic       stb_q;
    ex_mem_t    item_q;
    ex_mem_t    src;
    logic       ex_fire;
    logic       ex_is_mem;
    mem_size_e  acc_size;

    assign ex_fire   = i_ex_valid && ready_q;
    assign ex_is_mem = (i_ex.mem_op != MEM_NONE);
    assign acc_size  = (i_ex.mem_op == MEM_STORE) ? i_ex.store_size : i_ex.wb.load_size;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            state   <= IDLE;
            ready_q <= 1'b0;    // ready rises only once reset is gone
            stb_q   <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    ready_q <= 1'b1;
                    if (ex_fire && ex_is_mem)
                    begin
                        state   <= BUS;
                        ready_q <= 1'b0;    // stall upstream for the bus cycle
                        stb_q   <= 1'b1;
                    end
                end
                BUS:
                begin
                    if (i_wb_ack)
                    begin
                        state   <= IDLE;
                        ready_q <= 1'b1;
                        stb_q   <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (ex_fire)
            item_q <= i_ex;     // payload only
    end

    assign o_ex_ready = ready_q;

    // bus side, all taken from the latched item
    assign o_wb_cyc = (state == BUS);
    assign o_wb_stb = stb_q;
    assign o_wb_we  = o_wb_cyc && (item_q.mem_op == MEM_STORE);
    assign o_wb_adr = item_q.alu[NBITS-1:2];
    assign o_wb_dat = item_q.store_data << {item_q.alu[1:0], 3'b000};   // into its lane

    always_comb
    begin
        if (item_q.mem_op == MEM_LOAD)
            o_wb_sel = {(NBITS/8){1'b1}};   // loads read the whole word
        else
        begin
            case (item_q.store_size)
                SIZE_BYTE: o_wb_sel = {{(NBITS/8-1){1'b0}}, 1'b1} << item_q.alu[1:0];
                SIZE_HALF: o_wb_sel = {{(NBITS/8-2){1'b0}}, 2'b11} << item_q.alu[1:0];
                default:   o_wb_sel = {(NBITS/8){1'b1}};
            endcase
        end
    end

    // non-memory items pass straight through, bus items leave on ack
    assign src = (state == BUS) ? item_q : i_ex;

    always_comb
    begin
        o_mem.pc4      = src.pc4;
        o_mem.alu      = src.alu;
        o_mem.mem_data = (state == BUS) ? i_wb_dat : '0;
        o_mem.rd       = src.rd;
        o_mem.wb       = src.wb;
    end

    assign o_mem_valid = (state == BUS) ? i_wb_ack : (ex_fire && !ex_is_mem);

    a_stb_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_wb_stb |-> o_wb_cyc);

    a_half_align: assert property (@(posedge i_clk) disable iff (i_rst)
        (ex_fire && ex_is_mem && acc_size == SIZE_HALF) |-> !i_ex.alu[0]);

    a_word_align: assert property (@(posedge i_clk) disable iff (i_rst)
        (ex_fire && ex_is_mem && acc_size == SIZE_WORD) |-> (i_ex.alu[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: rtl/mips_mem_pkg.sv
`default_nettype none

package mips_mem_pkg;

    parameter int NBITS  = 32;  // data and address width
    parameter int RNBITS = 5;   // register index width

    // access size, shared by the store path and the load filter
    typedef enum logic [1:0]
    {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [1:0]
    {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // write-back source, covers link writes as well
    typedef enum logic [1:0]
    {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_src_e;

    // write-back controls, 6 bits
    typedef struct packed
    {
        wb_src_e    wb_src;
        logic       reg_write;
        mem_size_e  load_size;      // load filter size
        logic       zero_extend;
    } wb_ctrl_t;

    // item from execute, 111 bits
    typedef struct packed
    {
        logic [NBITS-1:0]   pc4;
        logic [NBITS-1:0]   alu;            // result or byte address
        logic [NBITS-1:0]   store_data;
        logic [RNBITS-1:0]  rd;
        mem_op_e            mem_op;
        mem_size_e          store_size;
        wb_ctrl_t           wb;
    } ex_mem_t;

    // item into write-back, 107 bits
    typedef struct packed
    {
        logic [NBITS-1:0]   pc4;
        logic [NBITS-1:0]   alu;
        logic [NBITS-1:0]   mem_data;       // raw RAM word, unfiltered
        logic [RNBITS-1:0]  rd;
        wb_ctrl_t           wb;
    } mem_wb_t;

endpackage

`default_nettype wire
